/* include/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_SIZE 16
`define NUM_REGS  4

// opcodes, instr[15:12]
`define OP_BNE   4'd0
`define OP_BEQ   4'd1
`define OP_BGZ   4'd2
`define OP_BLZ   4'd3
`define OP_ADI   4'd4
`define OP_ORI   4'd5
`define OP_LHI   4'd6
`define OP_LWD   4'd7
`define OP_SWD   4'd8
`define OP_JMP   4'd9
`define OP_JAL   4'd10
`define OP_RTYPE 4'd15

// function codes for R-type, instr[5:0]
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_NOT 6'd4
`define FN_TCP 6'd5
`define FN_SHL 6'd6
`define FN_SHR 6'd7
`define FN_JPR 6'd25
`define FN_JRL 6'd26
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`endif

/* verilog/cpuPkg.sv */
`include "cpu_defines.svh"

package cpuPkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_LHI,
        ALU_PASSA  // link value, taken unforwarded
    } aluOp_t;

    typedef struct packed {
        logic  valid;
        word_t pcPlus1;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        logic    valid;
        word_t   a;
        word_t   b;
        word_t   imm;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        aluOp_t  aluOp;
        logic    useImm;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        logic    memToReg;
        logic    isWwd;
        logic    isHalt;
    } idEx_t;

    typedef struct packed {
        logic    valid;
        word_t   aluResult;
        word_t   storeData;
        word_t   wwdVal;   // forwarded operand A
        regIdx_t rd;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        logic    memToReg;
        logic    isWwd;
        logic    isHalt;
    } exMem_t;

    typedef struct packed {
        logic    valid;
        word_t   aluResult;
        word_t   loadData;
        word_t   wwdVal;
        regIdx_t rd;
        logic    regWrite;
        logic    memToReg;
        logic    isWwd;
        logic    isHalt;
    } memWb_t;

endpackage

/* verilog/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           redirect,
    input  cpuPkg::word_t  target,
    input  logic           halted,
    output cpuPkg::word_t  imemAddr,
    input  cpuPkg::word_t  imemData,
    output cpuPkg::ifId_t  ifId
);

    cpuPkg::word_t pc;

    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ifId.valid <= 1'b0;
        end else if (halted) begin
            ifId.valid <= 1'b0;  // pc frozen, only bubbles from here
        end else if (redirect) begin
            pc <= target;
            ifId.valid <= 1'b0;  // squash the wrong-path fetch
        end else if (!stall) begin
            pc <= pc + 1'b1;
            ifId.valid <= 1'b1;
            ifId.pcPlus1 <= pc + 1'b1;
            ifId.instr <= imemData;
        end
    end

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decodeStage (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::ifId_t    ifId,
    output cpuPkg::idEx_t    idEx,
    input  cpuPkg::exMem_t   exMem,
    output cpuPkg::regIdx_t  rsAddr,
    output cpuPkg::regIdx_t  rtAddr,
    input  cpuPkg::word_t    rsData,
    input  cpuPkg::word_t    rtData,
    output logic             stall,
    output logic             redirect,
    output cpuPkg::word_t    target
);

    logic [3:0] op;
    logic [5:0] fn;
    cpuPkg::regIdx_t rs;
    cpuPkg::regIdx_t rt;
    cpuPkg::word_t signExt;
    cpuPkg::word_t zeroExt;
    cpuPkg::idEx_t ctrl;
    logic isBranch;
    logic isJump;
    logic isJumpReg;
    logic isLink;
    logic takeBranch;
    logic loadUse;
    logic srcHazard;

    assign op = ifId.instr[`WORD_SIZE-1:12];
    assign fn = ifId.instr[5:0];
    assign rs = ifId.instr[11:10];
    assign rt = ifId.instr[9:8];
    assign signExt = {{8{ifId.instr[7]}}, ifId.instr[7:0]};
    assign zeroExt = {8'b0, ifId.instr[7:0]};
    assign rsAddr = rs;
    assign rtAddr = rt;

    always_comb begin
        ctrl = '0;
        ctrl.a = rsData;
        ctrl.b = rtData;
        ctrl.imm = signExt;
        ctrl.rs = rs;
        ctrl.rt = rt;
        ctrl.rd = rt;  // I-type target
        ctrl.aluOp = cpuPkg::ALU_ADD;
        isBranch = 1'b0;
        isJump = 1'b0;
        isJumpReg = 1'b0;
        isLink = 1'b0;
        takeBranch = 1'b0;
        case (op)
            `OP_BNE: begin
                isBranch = 1'b1;
                takeBranch = rsData != rtData;
            end
            `OP_BEQ: begin
                isBranch = 1'b1;
                takeBranch = rsData == rtData;
            end
            `OP_BGZ: begin
                isBranch = 1'b1;
                takeBranch = !rsData[`WORD_SIZE-1] && rsData != '0;
            end
            `OP_BLZ: begin
                isBranch = 1'b1;
                takeBranch = rsData[`WORD_SIZE-1];
            end
            `OP_ADI: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_ORI, `OP_LHI: begin
                ctrl.imm = zeroExt;
                ctrl.aluOp = (op == `OP_ORI) ? cpuPkg::ALU_OR : cpuPkg::ALU_LHI;
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_LWD: begin
                ctrl.useImm = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            `OP_SWD: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            `OP_JMP: isJump = 1'b1;
            `OP_JAL: begin
                isJump = 1'b1;
                isLink = 1'b1;
            end
            `OP_RTYPE: begin
                ctrl.rd = ifId.instr[7:6];
                case (fn)
                    `FN_ADD: ctrl.regWrite = 1'b1;
                    `FN_SUB, `FN_AND, `FN_ORR, `FN_NOT, `FN_TCP, `FN_SHL, `FN_SHR: begin
                        ctrl.regWrite = 1'b1;
                        case (fn)
                            `FN_SUB: ctrl.aluOp = cpuPkg::ALU_SUB;
                            `FN_AND: ctrl.aluOp = cpuPkg::ALU_AND;
                            `FN_ORR: ctrl.aluOp = cpuPkg::ALU_OR;
                            `FN_NOT: ctrl.aluOp = cpuPkg::ALU_NOT;
                            `FN_TCP: ctrl.aluOp = cpuPkg::ALU_TCP;
                            `FN_SHL: ctrl.aluOp = cpuPkg::ALU_SHL;
                            default: ctrl.aluOp = cpuPkg::ALU_SHR;
                        endcase
                    end
                    `FN_WWD: ctrl.isWwd = 1'b1;
                    `FN_JPR: isJumpReg = 1'b1;
                    `FN_JRL: begin
                        isJumpReg = 1'b1;
                        isLink = 1'b1;
                    end
                    `FN_HLT: ctrl.isHalt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        if (isLink) begin  // r2 <= pc + 1
            ctrl.rd = 2'd2;
            ctrl.a = ifId.pcPlus1;
            ctrl.aluOp = cpuPkg::ALU_PASSA;
            ctrl.regWrite = 1'b1;
        end
    end

    // load result not ready for execute yet
    assign loadUse = idEx.valid && idEx.memRead && (idEx.rd == rs || idEx.rd == rt);

    // compare in decode needs sources already in the register file
    assign srcHazard = (isBranch || isJumpReg) &&
        ((idEx.valid && idEx.regWrite && (idEx.rd == rs || idEx.rd == rt)) ||
         (exMem.valid && exMem.regWrite && (exMem.rd == rs || exMem.rd == rt)));

    assign stall = ifId.valid && (loadUse || srcHazard);
    assign redirect = ifId.valid && !stall && (takeBranch || isJump || isJumpReg);

    assign target = isJumpReg ? rsData :
                    isJump    ? {ifId.pcPlus1[`WORD_SIZE-1:12], ifId.instr[11:0]} :
                                ifId.pcPlus1 + signExt;

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx <= ctrl;
            idEx.valid <= ifId.valid && !stall;  // bubble when held or empty
        end
    end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [$clog2(`NUM_REGS)-1:0]  rsAddr,
    input  logic [$clog2(`NUM_REGS)-1:0]  rtAddr,
    input  logic [$clog2(`NUM_REGS)-1:0]  wrAddr,
    input  logic [`WORD_SIZE-1:0]         wrData,
    input  logic                          wrEn,
    output logic [`WORD_SIZE-1:0]         rsData,
    output logic [`WORD_SIZE-1:0]         rtData
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    // write-before-read, writeback value seen by decode this cycle
    function automatic logic [`WORD_SIZE-1:0] readPort(
        input logic [$clog2(`NUM_REGS)-1:0] addr,
        input logic [`WORD_SIZE-1:0] stored
    );
        return (wrEn && wrAddr == addr) ? wrData : stored;
    endfunction

    always_comb begin
        rsData = readPort(rsAddr, regs[rsAddr]);
        rtData = readPort(rtAddr, regs[rtAddr]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::idEx_t   idEx,
    input  cpuPkg::memWb_t  memWb,
    input  cpuPkg::word_t   wbData,
    output cpuPkg::exMem_t  exMem
);

    cpuPkg::word_t fwdA;
    cpuPkg::word_t fwdB;
    cpuPkg::word_t opA;
    cpuPkg::word_t opB;
    cpuPkg::word_t result;

    // newest producer wins
    function automatic cpuPkg::word_t pickOperand(
        input cpuPkg::regIdx_t src,
        input cpuPkg::word_t decoded
    );
        if (exMem.valid && exMem.regWrite && exMem.rd == src) begin
            return exMem.aluResult;
        end else if (memWb.valid && memWb.regWrite && memWb.rd == src) begin
            return wbData;
        end
        return decoded;
    endfunction

    always_comb begin
        fwdA = pickOperand(idEx.rs, idEx.a);
        fwdB = pickOperand(idEx.rt, idEx.b);
        opA = (idEx.aluOp == cpuPkg::ALU_PASSA) ? idEx.a : fwdA;  // link comes from decode
        opB = idEx.useImm ? idEx.imm : fwdB;
    end

    always_comb begin
        case (idEx.aluOp)
            cpuPkg::ALU_ADD: result = opA + opB;
            cpuPkg::ALU_SUB: result = opA - opB;
            cpuPkg::ALU_AND: result = opA & opB;
            cpuPkg::ALU_OR:  result = opA | opB;
            cpuPkg::ALU_NOT: result = ~opA;
            cpuPkg::ALU_TCP: result = ~opA + 1'b1;
            cpuPkg::ALU_SHL: result = opA << 1;
            cpuPkg::ALU_SHR: result = {opA[$bits(opA)-1], opA[$bits(opA)-1:1]};  // arithmetic
            cpuPkg::ALU_LHI: result = {opB[7:0], 8'b0};
            default:         result = opA;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.aluResult <= result;
            exMem.storeData <= fwdB;
            exMem.wwdVal <= fwdA;
            exMem.rd <= idEx.rd;
            exMem.memRead <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.regWrite <= idEx.regWrite;
            exMem.memToReg <= idEx.memToReg;
            exMem.isWwd <= idEx.isWwd;
            exMem.isHalt <= idEx.isHalt;
        end
    end

endmodule

/* verilog/memWbStage.sv */
`timescale 1ns/1ps

module memWbStage (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::exMem_t  exMem,
    output logic            dmemRead,
    output logic            dmemWrite,
    output cpuPkg::word_t   dmemAddr,
    output cpuPkg::word_t   dmemWData,
    input  cpuPkg::word_t   dmemRData,
    output cpuPkg::memWb_t  memWb,
    output cpuPkg::word_t   wbData,
    output cpuPkg::word_t   numInst,
    output cpuPkg::word_t   outputPort,
    output logic            outputValid,
    output logic            halted
);

    logic active;

    // nothing younger than a HLT may act
    assign active = exMem.valid && !halted && !(memWb.valid && memWb.isHalt);

    assign dmemRead = active && exMem.memRead;
    assign dmemWrite = active && exMem.memWrite;
    assign dmemAddr = exMem.aluResult;
    assign dmemWData = exMem.storeData;

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;
    assign outputPort = memWb.wwdVal;
    assign outputValid = memWb.valid && memWb.isWwd;

    always_ff @(posedge clk) begin
        if (reset) begin
            memWb.valid <= 1'b0;
            numInst <= '0;
            halted <= 1'b0;
        end else begin
            memWb.valid <= active;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData <= dmemRData;
            memWb.wwdVal <= exMem.wwdVal;
            memWb.rd <= exMem.rd;
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.isWwd <= exMem.isWwd;
            memWb.isHalt <= exMem.isHalt;
            numInst <= numInst + memWb.valid;  // one retire per cycle at most
            if (memWb.valid && memWb.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* verilog/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
    input  logic           clk,
    input  logic           reset,
    output cpuPkg::word_t  imemAddr,
    input  cpuPkg::word_t  imemData,
    output logic           dmemRead,
    output logic           dmemWrite,
    output cpuPkg::word_t  dmemAddr,
    output cpuPkg::word_t  dmemWData,
    input  cpuPkg::word_t  dmemRData,
    output cpuPkg::word_t  numInst,
    output cpuPkg::word_t  outputPort,
    output logic           outputValid,
    output logic           halted
);

    cpuPkg::ifId_t ifId;
    cpuPkg::idEx_t idEx;
    cpuPkg::exMem_t exMem;
    cpuPkg::memWb_t memWb;
    cpuPkg::word_t target;
    cpuPkg::word_t rsData;
    cpuPkg::word_t rtData;
    cpuPkg::word_t wbData;
    cpuPkg::regIdx_t rsAddr;
    cpuPkg::regIdx_t rtAddr;
    logic stall;
    logic redirect;

    fetchStage fetch_i (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .halted   (halted),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .ifId     (ifId)
    );

    decodeStage decode_i (
        .clk      (clk),
        .reset    (reset),
        .ifId     (ifId),
        .idEx     (idEx),
        .exMem    (exMem),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rsData   (rsData),
        .rtData   (rtData),
        .stall    (stall),
        .redirect (redirect),
        .target   (target)
    );

    regFile regs_i (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wrAddr (memWb.rd),
        .wrData (wbData),
        .wrEn   (memWb.valid && memWb.regWrite),
        .rsData (rsData),
        .rtData (rtData)
    );

    executeStage execute_i (
        .clk    (clk),
        .reset  (reset),
        .idEx   (idEx),
        .memWb  (memWb),
        .wbData (wbData),
        .exMem  (exMem)
    );

    memWbStage memWb_i (
        .clk         (clk),
        .reset       (reset),
        .exMem       (exMem),
        .dmemRead    (dmemRead),
        .dmemWrite   (dmemWrite),
        .dmemAddr    (dmemAddr),
        .dmemWData   (dmemWData),
        .dmemRData   (dmemRData),
        .memWb       (memWb),
        .wbData      (wbData),
        .numInst     (numInst),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .halted      (halted)
    );

endmodule

/* test/cpuCore_chk.sv */
`timescale 1ns/1ps

module cpuCore_chk (
    input logic          clk,
    input logic          reset,
    input logic          dmemRead,
    input logic          dmemWrite,
    input logic          outputValid,
    input logic          halted,
    input cpuPkg::word_t numInst
);

    // sticky until reset
    haltHolds: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted fell without reset");

    memExclusive: assert property (@(posedge clk) disable iff (reset)
        !(dmemRead && dmemWrite))
        else $error("dmemRead and dmemWrite high together");

    noOutputAfterHalt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !outputValid)
        else $error("outputValid high while halted");

    // at most one retire per cycle
    countStep: assert property (@(posedge clk) disable iff (reset)
        !$stable(numInst) |-> numInst == $past(numInst) + 16'd1)
        else $error("numInst jumped by more than one");

endmodule

/* test/cpuCore_tb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuCore_tb;

    logic clk;
    logic reset;
    cpuPkg::word_t imemAddr;
    cpuPkg::word_t imemData;
    logic dmemRead;
    logic dmemWrite;
    cpuPkg::word_t dmemAddr;
    cpuPkg::word_t dmemWData;
    cpuPkg::word_t dmemRData;
    cpuPkg::word_t numInst;
    cpuPkg::word_t outputPort;
    logic outputValid;
    logic halted;

    cpuPkg::word_t imem [64];
    cpuPkg::word_t dmem [256];
    cpuPkg::word_t progMem [64];  // image copied into imem during reset
    cpuPkg::word_t expOut [$];
    int progLen;
    int expCount;
    int outIdx;
    int errors;
    int checkedOuts;
    int programs;
    int cycleCount = 0;
    int cycleLimit = 1000;

    cpuCore dut_i (
        .clk         (clk),
        .reset       (reset),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .dmemRead    (dmemRead),
        .dmemWrite   (dmemWrite),
        .dmemAddr    (dmemAddr),
        .dmemWData   (dmemWData),
        .dmemRData   (dmemRData),
        .numInst     (numInst),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .halted      (halted)
    );

    bind cpuCore cpuCore_chk chk_i (
        .clk         (clk),
        .reset       (reset),
        .dmemRead    (dmemRead),
        .dmemWrite   (dmemWrite),
        .outputValid (outputValid),
        .halted      (halted),
        .numInst     (numInst)
    );

    assign imemData = imem[imemAddr[5:0]];
    // inverted data unless the core strobes a read
    assign dmemRData = dmemRead ? dmem[dmemAddr[7:0]] : ~dmem[dmemAddr[7:0]];

    function automatic cpuPkg::word_t fillWord(input int i);
        return 16'((i & 255) * 257) ^ 16'ha5c3;
    endfunction

    // HLT with the address in the register fields
    function automatic cpuPkg::word_t haltFill(input int i);
        return {`OP_RTYPE, 6'(i), `FN_HLT};
    endfunction

    function automatic cpuPkg::word_t rType(input logic [5:0] fn, input int rs, input int rt,
                                            input int rd);
        return {`OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic cpuPkg::word_t iType(input logic [3:0] op, input int rs, input int rt,
                                            input int imm);
        return {op, 2'(rs), 2'(rt), 8'(imm)};
    endfunction

    function automatic cpuPkg::word_t jType(input logic [3:0] op, input int addr);
        return {op, 12'(addr)};
    endfunction

    // ISA-level model, fills expOut and returns the retired count
    function automatic int refRun();
        cpuPkg::word_t rf [4];
        cpuPkg::word_t mem [256];
        cpuPkg::word_t pc;
        cpuPkg::word_t ins;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t immS;
        cpuPkg::word_t addr;
        int count;
        logic done;
        expOut.delete();
        for (int i = 0; i < 4; i++) begin
            rf[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillWord(i);
        end
        pc = '0;
        count = 0;
        done = 1'b0;
        while (!done && count < 4096) begin
            ins = progMem[pc[5:0]];
            a = rf[ins[11:10]];
            b = rf[ins[9:8]];
            immS = {{8{ins[7]}}, ins[7:0]};
            addr = a + immS;
            count++;
            pc = pc + 16'd1;
            case (ins[15:12])
                `OP_BNE: if (a != b) pc = pc + immS;
                `OP_BEQ: if (a == b) pc = pc + immS;
                `OP_BGZ: if ($signed(a) > 0) pc = pc + immS;
                `OP_BLZ: if ($signed(a) < 0) pc = pc + immS;
                `OP_ADI: rf[ins[9:8]] = a + immS;
                `OP_ORI: rf[ins[9:8]] = a | {8'h00, ins[7:0]};
                `OP_LHI: rf[ins[9:8]] = {ins[7:0], 8'h00};
                `OP_LWD: rf[ins[9:8]] = mem[addr[7:0]];
                `OP_SWD: mem[addr[7:0]] = b;
                `OP_JMP: pc = {pc[15:12], ins[11:0]};
                `OP_JAL: begin
                    rf[2] = pc;
                    pc = {pc[15:12], ins[11:0]};
                end
                `OP_RTYPE: begin
                    case (ins[5:0])
                        `FN_ADD: rf[ins[7:6]] = a + b;
                        `FN_SUB: rf[ins[7:6]] = a - b;
                        `FN_AND: rf[ins[7:6]] = a & b;
                        `FN_ORR: rf[ins[7:6]] = a | b;
                        `FN_NOT: rf[ins[7:6]] = ~a;
                        `FN_TCP: rf[ins[7:6]] = -a;
                        `FN_SHL: rf[ins[7:6]] = a << 1;
                        `FN_SHR: rf[ins[7:6]] = $signed(a) >>> 1;
                        `FN_WWD: expOut.push_back(a);
                        `FN_JPR: pc = a;
                        `FN_JRL: begin
                            rf[2] = pc;
                            pc = a;
                        end
                        `FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
        return count;
    endfunction

    task automatic clearProg();
        for (int i = 0; i < 64; i++) begin
            progMem[i] = haltFill(i);
        end
        progLen = 0;
    endtask

    task automatic emit(input cpuPkg::word_t w);
        progMem[progLen] = w;
        progLen++;
    endtask

    task automatic showCounts();
        $display("errors: %0d, outputs checked: %0d, programs run: %0d",
                 errors, checkedOuts, programs);
    endtask

    task automatic expectLow(input string sig, input logic val);
        if (val !== 1'b0) begin
            errors++;
            $display("FAIL %s expected %h got %h", sig, 1'b0, val);
        end
    endtask

    task automatic buildRandom();
        int pick;
        int rs;
        int rt;
        int rd;
        clearProg();
        for (int n = 0; n < 30; n++) begin
            pick = $urandom_range(0, 9);
            rs = $urandom_range(0, 3);
            rt = $urandom_range(0, 3);
            rd = $urandom_range(0, 3);
            case (pick)
                0, 1, 2: emit(rType(6'($urandom_range(`FN_ADD, `FN_SHR)), rs, rt, rd));
                3: emit(iType(`OP_ADI, rs, rt, $urandom_range(0, 255)));
                4: emit(iType(`OP_ORI, rs, rt, $urandom_range(0, 255)));
                5: emit(iType(`OP_LHI, rs, rt, $urandom_range(0, 255)));
                6: emit(iType(`OP_LWD, rs, rt, $urandom_range(0, 255)));
                7: emit(iType(`OP_SWD, rs, rt, $urandom_range(0, 255)));
                default: emit(rType(`FN_WWD, rs, 0, 0));
            endcase
        end
        emit(rType(`FN_HLT, 0, 0, 0));
    endtask

    task automatic runProgram(input string name);
        expCount = refRun();
        programs++;
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        outIdx = 0;
        @(negedge clk);
        expectLow("outputValid", outputValid);
        expectLow("dmemRead", dmemRead);
        expectLow("dmemWrite", dmemWrite);
        expectLow("halted", halted);
        if (numInst !== 16'd0) begin
            errors++;
            $display("FAIL numInst expected %h got %h", 16'd0, numInst);
        end
        cycleLimit = cycleCount + 64 * expCount + 200;
        @(posedge clk);
        reset <= 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        if (outIdx != expOut.size()) begin
            errors++;
            $display("%s: missing outputs, got %0d of %0d", name, outIdx, expOut.size());
        end
        if (numInst !== 16'(expCount)) begin
            errors++;
            $display("FAIL numInst expected %h got %h", 16'(expCount), numInst);
        end
        repeat (8) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                errors++;
                $display("FAIL halted expected %h got %h", 1'b1, halted);
            end
            if (numInst !== 16'(expCount)) begin
                errors++;
                $display("FAIL numInst expected %h got %h", 16'(expCount), numInst);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                imem[i] <= progMem[i];
            end
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dmemWrite) begin
            dmem[dmemAddr[7:0]] <= dmemWData;
        end
    end

    // WWD stream against the reference, in order
    always @(negedge clk) begin
        if (!reset && outputValid) begin
            if (halted) begin
                errors++;
                $display("output %h appeared after halt", outputPort);
            end else if (outIdx >= expOut.size()) begin
                errors++;
                $display("extra output %h beyond the %0d expected", outputPort, expOut.size());
            end else begin
                if (outputPort !== expOut[outIdx]) begin
                    errors++;
                    $display("FAIL outputPort expected %h got %h", expOut[outIdx], outputPort);
                end
                outIdx++;
                checkedOuts++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!reset && cycleCount > cycleLimit) begin
            errors++;
            $display("timeout, halted not seen within the cycle limit %0d", cycleLimit);
            showCounts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf687));
        reset = 1'b1;
        errors = 0;
        checkedOuts = 0;
        programs = 0;
        outIdx = 0;

        // dependent ALU chain
        clearProg();
        emit(iType(`OP_ADI, 0, 1, 5));
        emit(iType(`OP_ADI, 1, 2, -3));  // from exMem
        emit(rType(`FN_ADD, 1, 2, 3));   // r1 via memWb
        emit(rType(`FN_SUB, 3, 1, 3));
        emit(rType(`FN_AND, 3, 2, 1));
        emit(rType(`FN_ORR, 1, 3, 2));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(rType(`FN_NOT, 2, 0, 3));
        emit(rType(`FN_TCP, 3, 0, 1));
        emit(rType(`FN_SHL, 1, 0, 2));
        emit(rType(`FN_SHR, 2, 0, 3));
        emit(rType(`FN_WWD, 3, 0, 0));
        emit(iType(`OP_LHI, 0, 1, 'h81));
        emit(iType(`OP_ORI, 1, 1, 'hf0));
        emit(rType(`FN_SHR, 1, 0, 2));   // sign fill
        emit(rType(`FN_WWD, 1, 0, 0));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(rType(`FN_HLT, 0, 0, 0));
        runProgram("alu");

        // loads and stores
        clearProg();
        emit(iType(`OP_ADI, 0, 1, 16));
        emit(iType(`OP_ADI, 0, 2, 77));
        emit(iType(`OP_SWD, 1, 2, 3));   // store of a fresh value
        emit(iType(`OP_LWD, 1, 3, 3));
        emit(rType(`FN_WWD, 3, 0, 0));   // load-use
        emit(iType(`OP_LWD, 1, 2, 0));
        emit(rType(`FN_ADD, 2, 3, 3));
        emit(rType(`FN_WWD, 3, 0, 0));
        emit(iType(`OP_ADI, 3, 3, 1));
        emit(iType(`OP_SWD, 1, 3, -1));
        emit(iType(`OP_LWD, 1, 1, -1));
        emit(rType(`FN_WWD, 1, 0, 0));
        emit(rType(`FN_HLT, 0, 0, 0));
        runProgram("memory");

        // branches and jumps, addresses matter here
        clearProg();
        emit(iType(`OP_ADI, 0, 1, 3));
        emit(iType(`OP_ADI, 0, 2, -1));
        emit(iType(`OP_BEQ, 1, 2, 1));   // source just written, not taken
        emit(rType(`FN_WWD, 1, 0, 0));
        emit(iType(`OP_BNE, 1, 2, 1));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(iType(`OP_BGZ, 1, 0, 1));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(iType(`OP_BLZ, 2, 0, 1));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(iType(`OP_BGZ, 2, 0, 1));   // 10, not taken
        emit(iType(`OP_BLZ, 1, 0, 1));   // not taken
        emit(iType(`OP_BEQ, 1, 1, 1));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(iType(`OP_BNE, 1, 1, 1));   // not taken
        emit(jType(`OP_JMP, 17));
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(jType(`OP_JAL, 22));        // 17, link 18
        emit(rType(`FN_WWD, 2, 0, 0));
        emit(iType(`OP_ADI, 0, 3, 25));
        emit(rType(`FN_JRL, 3, 0, 0));   // 20, link 21
        emit(rType(`FN_WWD, 1, 0, 0));
        emit(rType(`FN_WWD, 2, 0, 0));   // 22, subroutine
        emit(rType(`FN_JPR, 2, 0, 0));
        emit(rType(`FN_WWD, 1, 0, 0));
        emit(rType(`FN_WWD, 2, 0, 0));   // 25
        emit(rType(`FN_HLT, 0, 0, 0));
        runProgram("branch");

        for (int p = 0; p < 20; p++) begin
            buildRandom();
            runProgram($sformatf("random %0d", p));
        end

        showCounts();
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* cpuCore.f */
+incdir+include
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/cpuCore.sv
test/cpuCore_chk.sv
test/cpuCore_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuCore_tb -f cpuCore.f -Mdir obj_dir
	./obj_dir/VcpuCore_tb | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
